// File: bench/tb_chol_model.svh
`ifndef TB_CHOL_MODEL_SVH
`define TB_CHOL_MODEL_SVH

// ====================
// Reference model
// ====================

function automatic int elem_pos(int i, int k);
    return i * (i + 1) / 2 + k;  // Row by row lower triangle
endfunction

function automatic logic [TRI_W-1:0] pack_a();
    logic [TRI_W-1:0] v;
    v = '0;
    for (int i = 0; i < N; i++) begin
        for (int k = 0; k <= i; k++) begin
            v[FW * elem_pos(i, k) +: FW] = a_mat[i][k];
        end
    end
    return v;
endfunction

// Floor of the square root, one bit at a time from the top
function automatic logic [63:0] int_sqrt(logic [63:0] x);
    logic [63:0] r;
    logic [63:0] t;
    r = '0;
    for (int b = 31; b >= 0; b--) begin
        t = r | (64'd1 << b);
        if (t * t <= x) begin
            r = t;
        end
    end
    return r;
endfunction

// A = M * M^T with M lower, diagonal in [1.0, 4.0), off-diagonal in [-1.0, 1.0)
task automatic gen_spd();
    logic signed [31:0] m [N][N];
    logic signed [63:0] sum;
    logic signed [63:0] wa;
    logic signed [63:0] wb;
    for (int i = 0; i < N; i++) begin
        for (int k = 0; k < N; k++) begin
            m[i][k] = '0;
            if (k == i) begin
                m[i][k] = 32'h0001_0000 + (next_random() & 32'h0002_ffff);
            end else if (k < i) begin
                m[i][k] = (next_random() & 32'h0001_ffff) - 32'h0001_0000;
            end
        end
    end
    for (int i = 0; i < N; i++) begin
        for (int j = 0; j <= i; j++) begin
            sum = '0;
            for (int k = 0; k <= j; k++) begin
                wa  = 64'(m[i][k]);
                wb  = 64'(m[j][k]);
                sum = sum + wa * wb;
            end
            a_mat[i][j] = sum[47:16];  // Q32.32 back to Q16.16
        end
    end
endtask

task automatic model_cholesky();
    logic signed [63:0] sum;
    logic signed [63:0] wa;
    logic signed [63:0] wb;
    logic signed [63:0] wide;
    logic signed [63:0] root;
    logic signed [63:0] q;
    logic signed [31:0] value;
    for (int i = 0; i < N; i++) begin
        for (int k = 0; k < N; k++) begin
            l_exp[i][k] = '0;
        end
    end
    for (int j = 0; j < N; j++) begin
        for (int i = j; i < N; i++) begin
            sum = '0;
            for (int k = 0; k < j; k++) begin
                wa  = 64'(l_exp[i][k]);
                wb  = 64'(l_exp[j][k]);
                sum = sum + wa * wb;
            end
            value = a_mat[i][j] - sum[47:16];
            wide  = 64'(value);
            if (i == j) begin
                root        = (value <= 0) ? 64'sd0 : int_sqrt(wide <<< 16);
                l_exp[j][j] = root[31:0];
            end else begin
                q           = (root == 0) ? 64'sd0 : (wide <<< 16) / root;  // Toward zero
                l_exp[i][j] = q[31:0];
            end
        end
    end
endtask

`endif

// File: bench/tb_cholesky.sv
`timescale 1ns/100ps

module tb_cholesky;

    localparam int N           = 5;
    localparam int FW          = 32;
    localparam int TRI_W       = FW * N * (N + 1) / 2;
    localparam int PERIOD      = 4;
    localparam int NUM_MATS    = 34;                   // Matrices started over all tests
    localparam int COL_COST    = N + 1 + 25 + 49 + 1;  // Bound for one column
    localparam int WATCHDOG_NS = 2 * (NUM_MATS * N * COL_COST + 500) * PERIOD;

    logic             clk;
    logic             rst;
    logic             a_valid;
    logic [TRI_W-1:0] a_bus;
    logic [TRI_W-1:0] l_bus;
    logic             l_valid;

    logic [31:0]        rng_state;
    logic signed [31:0] a_mat [N][N];  // Lower triangle used
    logic signed [31:0] l_exp [N][N];
    int                 pulse_count = 0;
    int                 check_count;
    int                 err_count;
    int                 test_count;
    int                 test_errs;

    cholesky_top #(.N(N)) i_cholesky_top (
        .clk     (clk),
        .rst     (rst),
        .A_valid (a_valid),
        .A       (a_bus),
        .L       (l_bus),
        .L_valid (l_valid)
    );

    always #(PERIOD / 2) clk = ~clk;

    always @(negedge clk) begin
        if (l_valid === 1'b1) begin
            pulse_count = pulse_count + 1;
        end
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    `include "tb_chol_model.svh"

    // ====================
    // Helpers
    // ====================

    task automatic check_value(string name, logic [31:0] got, logic [31:0] expected);
        check_count++;
        if (got !== expected) begin
            err_count++;
            $display("ERROR at %0d ns: %s = %h, expected %h", $time, name, got, expected);
        end
    endtask

    task automatic end_test(string name);
        test_count++;
        $display("[%0d] %s done, %0d errors", test_count, name, err_count - test_errs);
        test_errs = err_count;
    endtask

    task automatic strobe_a(logic [TRI_W-1:0] value);
        @(posedge clk);
        #1;
        a_bus   = value;
        a_valid = 1'b1;
        @(posedge clk);
        #1;
        a_valid = 1'b0;
    endtask

    task automatic wait_l_valid();
        do @(negedge clk); while (l_valid !== 1'b1);
    endtask

    task automatic compare_l();
        for (int i = 0; i < N; i++) begin
            for (int k = 0; k <= i; k++) begin
                check_value($sformatf("L[%0d][%0d]", i, k),
                            l_bus[FW * elem_pos(i, k) +: FW], l_exp[i][k]);
            end
        end
    endtask

    task automatic run_and_check(logic [TRI_W-1:0] value);
        int start;
        start = pulse_count;
        strobe_a(value);
        wait_l_valid();
        compare_l();
        repeat (4) @(negedge clk);
        check_value("L_valid pulses", pulse_count - start, 1);
    endtask

    // ====================
    // Tests
    // ====================

    initial begin
        logic [TRI_W-1:0] other_a;
        logic [TRI_W-1:0] snapshot;
        int               start;
        int               changes;
        clk         = 1'b0;
        rst         = 1'b1;
        a_valid     = 1'b0;
        a_bus       = '0;
        rng_state   = 32'hee4e39b3;
        check_count = 0;
        err_count   = 0;
        test_count  = 0;
        test_errs   = 0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        repeat (20) begin
            @(negedge clk);
            check_value("L_valid", 32'(l_valid), 32'd0);
        end
        for (int i = 0; i < N; i++) begin
            for (int k = 0; k < N; k++) begin
                l_exp[i][k] = '0;
            end
        end
        compare_l();
        end_test("reset state");

        for (int i = 0; i < N; i++) begin
            for (int k = 0; k < N; k++) begin
                a_mat[i][k] = (i == k) ? 32'sh0004_0000 : 32'sh0;
                l_exp[i][k] = (i == k) ? 32'sh0002_0000 : 32'sh0;  // sqrt(4.0)
            end
        end
        run_and_check(pack_a());
        end_test("identity x4");

        repeat (30) begin
            gen_spd();
            model_cholesky();
            run_and_check(pack_a());
        end
        end_test("random SPD");

        gen_spd();
        other_a = pack_a();
        gen_spd();
        model_cholesky();
        start = pulse_count;
        strobe_a(pack_a());
        repeat (20) @(posedge clk);
        strobe_a(other_a);  // All strobes land well before the last column
        repeat (80) @(posedge clk);
        strobe_a(other_a);
        repeat (150) @(posedge clk);
        strobe_a(other_a);
        wait_l_valid();
        compare_l();
        repeat (4) @(negedge clk);
        check_value("L_valid pulses", pulse_count - start, 1);
        end_test("A_valid while busy");

        for (int i = 0; i < N; i++) begin
            for (int k = 0; k < N; k++) begin
                a_mat[i][k] = (i == k) ? 32'sh0001_0000 : 32'sh0;
            end
        end
        a_mat[1][0] = 32'sh0002_0000;  // Column 1 reduces to -3.0
        a_mat[2][1] = 32'sh0000_8000;  // Divided by a zero root
        a_mat[3][0] = 32'sh0000_4000;
        model_cholesky();
        run_and_check(pack_a());
        end_test("non-positive diagonal");

        gen_spd();
        model_cholesky();
        start = pulse_count;
        strobe_a(pack_a());
        wait_l_valid();
        snapshot = l_bus;
        changes  = 0;
        repeat (50) begin
            @(negedge clk);
            if (l_bus !== snapshot) begin
                changes++;
            end
        end
        check_value("L changes after L_valid", changes, 0);
        compare_l();
        check_value("L_valid pulses", pulse_count - start, 1);
        end_test("L hold");

        $display("Summary: %0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
        if (err_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the DUT gave no result within %0d ns", WATCHDOG_NS);
        $display("Test failed");
        $finish;
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# Compile with Verilator and run the Cholesky testbench
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sources.f --top-module tb_cholesky -o tb_cholesky_sim

./obj_dir/tb_cholesky_sim > sim.log 2>&1
cat sim.log

if grep -q "^Test passed$" sim.log; then
    exit 0
else
    exit 1
fi

// File: sources.f
+incdir+bench
src/chol_num_pkg.sv
src/chol_seq_pkg.sv
src/column_scheduler.sv
src/diag_root.sv
src/row_lane.sv
src/factor_store.sv
src/cholesky_top.sv
bench/tb_cholesky.sv

// File: src/chol_num_pkg.sv
package chol_num_pkg;

    // ====================
    // Number format
    // ====================

    localparam int FIX_W     = 32;
    localparam int ACC_W     = 64;
    localparam int FRAC_BITS = 16;

    typedef logic signed [FIX_W-1:0] fix_t;  // Q16.16 element
    typedef logic signed [ACC_W-1:0] acc_t;  // Sum of full-width products

    // ====================
    // Arithmetic units
    // ====================

    localparam int ROOT_STEPS = 24;  // One root bit per step
    localparam int DIV_STEPS  = 48;  // One quotient bit per step

    // Full 64-bit product of two elements, Q32.32
    function automatic acc_t fix_mul(fix_t a, fix_t b);
        return acc_t'(a) * acc_t'(b);
    endfunction

    // Back to Q16.16 by taking bits 47..16 of the sum
    function automatic fix_t acc_to_fix(acc_t sum);
        return sum[FRAC_BITS +: FIX_W];
    endfunction

endpackage

// File: src/chol_seq_pkg.sv
package chol_seq_pkg;

    // ====================
    // Matrix layout
    // ====================

    // Lower triangle packed row by row: A11, A21, A22, A31 ...
    function automatic int tri_index(int i, int k);
        return i * (i + 1) / 2 + k;
    endfunction

    function automatic int tri_size(int n);
        return n * (n + 1) / 2;
    endfunction

    function automatic int col_width(int n);
        return (n > 1) ? $clog2(n) : 1;
    endfunction

    // ====================
    // Scheduling
    // ====================

    typedef enum logic [2:0] {
        IDLE,
        MAC,
        SUB,
        ROOT,
        DIV,
        STORE
    } sched_state_e;

    // Same command goes to the diagonal unit and every lane
    typedef struct packed {
        logic               clear;
        logic               mac_en;
        logic               sub_go;
        logic               root_go;
        logic               div_go;
        chol_num_pkg::fix_t col_l;   // L(j,k) at the current step
        logic [3:0]         step;    // MAC step k
    } lane_cmd_t;

    typedef struct packed {
        logic               active;  // Row j+1+r exists
        chol_num_pkg::fix_t a_elem;  // A(i,j)
        chol_num_pkg::fix_t l_row;   // L(i,k)
    } lane_op_t;

endpackage

// File: src/cholesky_top.sv
`timescale 1ns/100ps

module cholesky_top #(
    parameter  int N     = 5,
    localparam int TRI_W = chol_num_pkg::FIX_W * chol_seq_pkg::tri_size(N)
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             A_valid,
    input  logic [TRI_W-1:0] A,
    output logic [TRI_W-1:0] L,
    output logic             L_valid
);

    localparam int COL_W = chol_seq_pkg::col_width(N);

    chol_seq_pkg::lane_cmd_t cmd;
    chol_seq_pkg::lane_op_t  ops [N-1];
    chol_num_pkg::fix_t      quots [N-1];
    chol_num_pkg::fix_t      a_diag;
    chol_num_pkg::fix_t      root;       // Also the divisor of every lane
    logic                    root_done;
    logic [N-2:0]            lane_done;  // All active lanes finish together
    logic                    col_store;
    logic                    last_col;
    logic [COL_W-1:0]        col;

    column_scheduler #(.N(N)) u_sched (
        .clk       (clk),
        .rst       (rst),
        .A_valid   (A_valid),
        .A         (A),
        .L         (L),
        .root_done (root_done),
        .div_done  (lane_done[0]),
        .cmd       (cmd),
        .ops       (ops),
        .a_diag    (a_diag),
        .col_store (col_store),
        .col       (col),
        .last_col  (last_col)
    );

    diag_root #(.N(N)) u_diag (
        .clk       (clk),
        .rst       (rst),
        .cmd       (cmd),
        .a_diag    (a_diag),
        .root      (root),
        .root_done (root_done)
    );

    // ====================
    // Row lanes
    // ====================

    for (genvar r = 0; r < N - 1; r++) begin : g_lane
        row_lane #(.N(N)) u_lane (
            .clk      (clk),
            .rst      (rst),
            .cmd      (cmd),
            .op       (ops[r]),
            .divisor  (root),
            .quot     (quots[r]),
            .div_done (lane_done[r])
        );
    end

    factor_store #(.N(N)) u_store (
        .clk       (clk),
        .rst       (rst),
        .col_store (col_store),
        .col       (col),
        .last_col  (last_col),
        .root      (root),
        .quots     (quots),
        .L         (L),
        .L_valid   (L_valid)
    );

endmodule

// File: src/column_scheduler.sv
`timescale 1ns/100ps

module column_scheduler #(
    parameter  int N     = 5,
    localparam int TRI_W = chol_num_pkg::FIX_W * chol_seq_pkg::tri_size(N),
    localparam int COL_W = chol_seq_pkg::col_width(N)
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    A_valid,
    input  logic [TRI_W-1:0]        A,
    input  logic [TRI_W-1:0]        L,
    input  logic                    root_done,
    input  logic                    div_done,
    output chol_seq_pkg::lane_cmd_t cmd,
    output chol_seq_pkg::lane_op_t  ops [N-1],
    output chol_num_pkg::fix_t      a_diag,
    output logic                    col_store,
    output logic [COL_W-1:0]        col,
    output logic                    last_col
);

    localparam int FW = chol_num_pkg::FIX_W;

    chol_seq_pkg::sched_state_e state;

    logic [TRI_W-1:0] a_q;        // Matrix latched on A_valid
    logic [3:0]       step;
    logic             first;      // First cycle of ROOT or DIV
    logic             last_step;

    function automatic chol_num_pkg::fix_t elem(logic [TRI_W-1:0] mat, int i, int k);
        return mat[FW * chol_seq_pkg::tri_index(i, k) +: FW];
    endfunction

    assign last_step = (COL_W'(step) + COL_W'(1)) == col;
    assign last_col  = (col == COL_W'(N - 1));
    assign col_store = (state == chol_seq_pkg::STORE);

    // ====================
    // Column / phase FSM
    // ====================

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= chol_seq_pkg::IDLE;
            col   <= '0;
            step  <= '0;
            first <= 1'b0;
        end else begin
            first <= 1'b0;
            case (state)
                chol_seq_pkg::IDLE: begin
                    if (A_valid) begin
                        col   <= '0;
                        step  <= '0;
                        state <= chol_seq_pkg::SUB;  // Column 0 has nothing to sum
                    end
                end
                chol_seq_pkg::MAC: begin
                    if (last_step) begin
                        step  <= '0;
                        state <= chol_seq_pkg::SUB;
                    end else begin
                        step <= step + 4'd1;
                    end
                end
                chol_seq_pkg::SUB: begin
                    first <= 1'b1;
                    state <= chol_seq_pkg::ROOT;
                end
                chol_seq_pkg::ROOT: begin
                    if (root_done) begin
                        first <= ~last_col;
                        state <= last_col ? chol_seq_pkg::STORE : chol_seq_pkg::DIV;
                    end
                end
                chol_seq_pkg::DIV: begin
                    if (div_done) begin
                        state <= chol_seq_pkg::STORE;
                    end
                end
                chol_seq_pkg::STORE: begin
                    if (last_col) begin
                        state <= chol_seq_pkg::IDLE;
                    end else begin
                        col   <= col + COL_W'(1);
                        state <= chol_seq_pkg::MAC;  // Every later column has j >= 1 steps
                    end
                end
                default: state <= chol_seq_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == chol_seq_pkg::IDLE && A_valid) begin
            a_q <= A;
        end
    end

    // ====================
    // Operand selection
    // ====================

    always_comb begin
        cmd         = '0;
        cmd.clear   = (state == chol_seq_pkg::IDLE) || (state == chol_seq_pkg::STORE);
        cmd.mac_en  = (state == chol_seq_pkg::MAC);
        cmd.sub_go  = (state == chol_seq_pkg::SUB);
        cmd.root_go = (state == chol_seq_pkg::ROOT) && first;
        cmd.div_go  = (state == chol_seq_pkg::DIV) && first;
        cmd.col_l   = elem(L, int'(col), int'(step));  // L(j,k)
        cmd.step    = step;
    end

    assign a_diag = elem(a_q, int'(col), int'(col));

    always_comb begin
        int row;
        for (int r = 0; r < N - 1; r++) begin
            row           = int'(col) + 1 + r;
            ops[r].active = (row < N);
            if (row >= N) begin
                row = int'(col);  // Keep the index inside the triangle
            end
            ops[r].a_elem = elem(a_q, row, int'(col));
            ops[r].l_row  = elem(L, row, int'(step));
        end
    end

endmodule

// File: src/diag_root.sv
`timescale 1ns/100ps

module diag_root #(
    parameter int N = 5
) (
    input  logic                    clk,
    input  logic                    rst,
    input  chol_seq_pkg::lane_cmd_t cmd,
    input  chol_num_pkg::fix_t      a_diag,
    output chol_num_pkg::fix_t      root,
    output logic                    root_done
);

    localparam int RW    = chol_num_pkg::ROOT_STEPS;  // Root bits
    localparam int RAD_W = 2 * RW;
    localparam int REM_W = RW + 3;
    localparam int CNT_W = $clog2(RW);

    chol_num_pkg::acc_t acc;
    chol_num_pkg::fix_t value;  // Reduced diagonal

    logic [RAD_W-1:0] rad_q, rad_cur, rad_init;
    logic [REM_W-1:0] rem_q, rem_cur, rem_sh, rem_next, trial;
    logic [RW-1:0]    root_q, root_cur, root_next;
    logic [CNT_W-1:0] cnt;
    logic             busy;

    always_ff @(posedge clk) begin
        if (cmd.clear) begin
            acc <= '0;
        end else if (cmd.mac_en) begin
            acc <= acc + chol_num_pkg::fix_mul(cmd.col_l, cmd.col_l);
        end
        if (cmd.sub_go) begin
            value <= a_diag - chol_num_pkg::acc_to_fix(acc);
        end
    end

    // ====================
    // Bit-serial root
    // ====================

    // Non-positive value gives a zero root
    assign rad_init = (value > 0) ? RAD_W'(unsigned'(value)) << chol_num_pkg::FRAC_BITS : '0;

    always_comb begin
        rad_cur  = cmd.root_go ? rad_init : rad_q;  // First step straight from value
        rem_cur  = cmd.root_go ? '0 : rem_q;
        root_cur = cmd.root_go ? '0 : root_q;
        rem_sh   = {rem_cur[REM_W-3:0], rad_cur[RAD_W-1 -: 2]};
        trial    = REM_W'({root_cur, 2'b01});
        if (rem_sh >= trial) begin
            rem_next  = rem_sh - trial;
            root_next = {root_cur[RW-2:0], 1'b1};
        end else begin
            rem_next  = rem_sh;
            root_next = {root_cur[RW-2:0], 1'b0};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            cnt       <= '0;
            root_done <= 1'b0;
        end else begin
            root_done <= 1'b0;
            if (cmd.root_go) begin
                busy <= 1'b1;
                cnt  <= CNT_W'(RW - 1);
            end else if (busy) begin
                cnt <= cnt - CNT_W'(1);
                if (cnt == CNT_W'(1)) begin
                    busy      <= 1'b0;
                    root_done <= 1'b1;  // Last bit just registered
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cmd.root_go || busy) begin
            rad_q  <= rad_cur << 2;
            rem_q  <= rem_next;
            root_q <= root_next;
        end
    end

    assign root = {{(chol_num_pkg::FIX_W - RW){1'b0}}, root_q};

endmodule

// File: src/factor_store.sv
`timescale 1ns/100ps

module factor_store #(
    parameter  int N     = 5,
    localparam int TRI_W = chol_num_pkg::FIX_W * chol_seq_pkg::tri_size(N),
    localparam int COL_W = chol_seq_pkg::col_width(N)
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               col_store,
    input  logic [COL_W-1:0]   col,
    input  logic               last_col,
    input  chol_num_pkg::fix_t root,
    input  chol_num_pkg::fix_t quots [N-1],
    output logic [TRI_W-1:0]   L,
    output logic               L_valid
);

    localparam int FW = chol_num_pkg::FIX_W;

    // ====================
    // Column write-back
    // ====================

    always_ff @(posedge clk) begin
        if (rst) begin
            L       <= '0;
            L_valid <= 1'b0;
        end else begin
            L_valid <= col_store && last_col;  // Whole factor is in place
            if (col_store) begin
                // Diagonal L(j,j)
                L[FW * chol_seq_pkg::tri_index(int'(col), int'(col)) +: FW] <= root;
                for (int r = 0; r < N - 1; r++) begin
                    // Lane r holds L(j+1+r, j)
                    if (int'(col) + 1 + r < N) begin
                        L[FW * chol_seq_pkg::tri_index(int'(col) + 1 + r, int'(col)) +: FW]
                            <= quots[r];
                    end
                end
            end
        end
    end

endmodule

// File: src/row_lane.sv
`timescale 1ns/100ps

module row_lane #(
    parameter int N = 5
) (
    input  logic                    clk,
    input  logic                    rst,
    input  chol_seq_pkg::lane_cmd_t cmd,
    input  chol_seq_pkg::lane_op_t  op,
    input  chol_num_pkg::fix_t      divisor,
    output chol_num_pkg::fix_t      quot,
    output logic                    div_done
);

    localparam int FW    = chol_num_pkg::FIX_W;
    localparam int DW    = chol_num_pkg::DIV_STEPS;  // Dividend and quotient bits
    localparam int REM_W = FW + 1;
    localparam int CNT_W = $clog2(DW);

    chol_num_pkg::acc_t acc;
    chol_num_pkg::fix_t value;  // A(i,j) minus the sum

    logic [FW-1:0]    mag;
    logic [DW-1:0]    num_q, num_cur, num_init, num_next;
    logic [REM_W-1:0] rem_q, rem_cur, rem_sh, rem_next, den;
    logic [CNT_W-1:0] cnt;
    logic [FW-1:0]    q_lo;
    logic             busy;
    logic             neg_q;
    logic             zero_q;
    logic             mac_ok;
    logic             go;

    assign mac_ok = cmd.mac_en && op.active;
    assign go     = cmd.div_go && op.active;

    always_ff @(posedge clk) begin
        if (cmd.clear) begin
            acc <= '0;
        end else if (mac_ok) begin
            acc <= acc + chol_num_pkg::fix_mul(op.l_row, cmd.col_l);
        end
        if (cmd.sub_go && op.active) begin
            value <= op.a_elem - chol_num_pkg::acc_to_fix(acc);
        end
    end

    // ====================
    // Signed division
    // ====================

    assign mag      = value[FW-1] ? FW'(-value) : FW'(value);  // Magnitude fits as unsigned
    assign num_init = DW'(mag) << chol_num_pkg::FRAC_BITS;
    assign den      = REM_W'(unsigned'(divisor));

    always_comb begin
        num_cur = go ? num_init : num_q;
        rem_cur = go ? '0 : rem_q;
        rem_sh  = {rem_cur[REM_W-2:0], num_cur[DW-1]};
        if (rem_sh >= den) begin
            rem_next = rem_sh - den;
            num_next = {num_cur[DW-2:0], 1'b1};  // Quotient bits enter at the bottom
        end else begin
            rem_next = rem_sh;
            num_next = {num_cur[DW-2:0], 1'b0};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            cnt      <= '0;
            div_done <= 1'b0;
        end else begin
            div_done <= 1'b0;
            if (go) begin
                busy <= 1'b1;
                cnt  <= CNT_W'(DW - 1);
            end else if (busy) begin
                cnt <= cnt - CNT_W'(1);
                if (cnt == CNT_W'(1)) begin
                    busy     <= 1'b0;
                    div_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (go || busy) begin
            num_q <= num_next;
            rem_q <= rem_next;
        end
        if (go) begin
            neg_q  <= value[FW-1];
            zero_q <= (divisor == '0);
        end
    end

    assign q_lo = num_q[FW-1:0];
    assign quot = zero_q ? '0 : (neg_q ? -q_lo : q_lo);  // Truncated toward zero

endmodule
